// File: apb_csr.sv
`timescale 1ns/10ps

module apb_csr #(
    parameter int IMEM_DEPTH = 16
) (
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [11:0]                paddr_i,
    input  logic [31:0]                pwdata_i,
    output logic [31:0]                prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,
    input  la_branch_pkg::exec_state_e state_i,
    input  logic [31:0]                pc_i,
    input  logic [7:0]                 retired_i,
    input  logic [31:0]                gpr_rdata_i,
    output logic [4:0]                 gpr_raddr_o,
    output logic                       host_gpr_we_o,
    output logic                       host_imem_we_o,
    output logic [7:0]                 host_addr_o,
    output logic [31:0]                host_wdata_o,
    output logic                       pc_wr_o,
    output logic                       start_o,
    output logic [7:0]                 step_count_o
);
    import la_branch_pkg::*;

    localparam logic [11:0] GPR_SPAN  = 12'h080;
    localparam logic [11:0] IMEM_SPAN = 12'(IMEM_DEPTH * 4);

    logic access;
    logic busy;
    logic hit_ctrl;
    logic hit_status;
    logic hit_pc;
    logic hit_retired;
    logic hit_gpr;
    logic hit_imem;
    logic mapped;
    logic wr_ok;

    assign access = psel_i && penable_i;
    assign busy   = (state_i == S_FETCH) || (state_i == S_EXEC) || (state_i == S_WB);

    assign hit_ctrl    = (paddr_i == ADDR_CTRL);
    assign hit_status  = (paddr_i == ADDR_STATUS);
    assign hit_pc      = (paddr_i == ADDR_PC);
    assign hit_retired = (paddr_i == ADDR_RETIRED);
    assign hit_gpr     = (paddr_i >= ADDR_GPR_BASE) && (paddr_i < ADDR_GPR_BASE + GPR_SPAN);
    assign hit_imem    = (paddr_i >= ADDR_IMEM_BASE) && (paddr_i < ADDR_IMEM_BASE + IMEM_SPAN);
    assign mapped      = hit_ctrl || hit_status || hit_pc || hit_retired || hit_gpr || hit_imem;

    // no wait states
    assign pready_o = 1'b1;

    // refused: unmapped, read-only target, or anything that alters the run while busy
    assign pslverr_o = access && (!mapped ||
                       (pwrite_i && (hit_status || hit_retired ||
                       (busy && (hit_ctrl || hit_pc || hit_gpr || hit_imem)))));

    assign wr_ok = access && pwrite_i && !pslverr_o;

    assign host_gpr_we_o  = wr_ok && hit_gpr;
    assign host_imem_we_o = wr_ok && hit_imem;
    assign pc_wr_o        = wr_ok && hit_pc;
    assign start_o        = wr_ok && hit_ctrl;

    // word index inside the selected window
    assign host_addr_o  = paddr_i[9:2];
    assign host_wdata_o = pwdata_i;
    assign gpr_raddr_o  = paddr_i[6:2];
    assign step_count_o = pwdata_i[7:0];

    always_comb begin
        prdata_o = 32'd0;
        if (access && !pwrite_i) begin
            if (hit_status) begin
                prdata_o = {29'd0, state_i == S_FAULT, state_i == S_DONE, busy};
            end else if (hit_pc) begin
                prdata_o = pc_i;
            end else if (hit_retired) begin
                prdata_o = {24'd0, retired_i};
            end else if (hit_gpr) begin
                prdata_o = gpr_rdata_i;
            end
            // imem and ctrl read back as zero
        end
    end

endmodule

// File: branch_core_top.sv
`timescale 1ns/10ps

module branch_core_top #(
    parameter int IMEM_DEPTH = 16
) (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [11:0] paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o
);
    import la_branch_pkg::*;

    localparam int IAW = $clog2(IMEM_DEPTH);

    exec_state_e state;
    alu_op_e     aluop;
    logic        busy;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        fetch_en;
    logic        dec_valid;
    logic [9:0]  dec_raddr;
    logic [31:0] imm;
    logic        dec_we;
    logic [4:0]  dec_waddr;
    logic [31:0] rj_data;
    logic [31:0] rd_data;
    logic [31:0] next_pc;
    logic [31:0] link;
    logic        fsm_gpr_we;
    logic [4:0]  fsm_gpr_waddr;
    logic [31:0] fsm_gpr_wdata;
    logic        retire;
    logic        steps_zero;
    logic [7:0]  retired;
    logic [4:0]  csr_gpr_raddr;
    logic        host_gpr_we;
    logic        host_imem_we;
    logic [7:0]  host_addr;
    logic [31:0] host_wdata;
    logic        pc_wr;
    logic        start;
    logic [7:0]  step_count;
    logic [4:0]  gpr_raddr_a;
    logic        gpr_we;
    logic [4:0]  gpr_waddr;
    logic [31:0] gpr_wdata;

    assign busy = (state == S_FETCH) || (state == S_EXEC) || (state == S_WB);

    // sequencer owns the register file during a run
    assign gpr_raddr_a = busy ? dec_raddr[4:0] : csr_gpr_raddr;
    assign gpr_we      = busy ? fsm_gpr_we : host_gpr_we;
    assign gpr_waddr   = busy ? fsm_gpr_waddr : host_addr[4:0];
    assign gpr_wdata   = busy ? fsm_gpr_wdata : host_wdata;

    apb_csr #(
        .IMEM_DEPTH(IMEM_DEPTH)
    ) u_csr (
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
        .pready_o(pready_o), .pslverr_o(pslverr_o), .state_i(state),
        .pc_i(pc), .retired_i(retired), .gpr_rdata_i(rj_data),
        .gpr_raddr_o(csr_gpr_raddr), .host_gpr_we_o(host_gpr_we),
        .host_imem_we_o(host_imem_we), .host_addr_o(host_addr),
        .host_wdata_o(host_wdata), .pc_wr_o(pc_wr), .start_o(start),
        .step_count_o(step_count)
    );

    inst_mem #(
        .IMEM_DEPTH(IMEM_DEPTH)
    ) u_imem (
        .clk_i(clk_i), .host_we_i(host_imem_we), .host_addr_i(host_addr[IAW-1:0]),
        .host_wdata_i(host_wdata), .fetch_en_i(fetch_en),
        .fetch_addr_i(pc[IAW+1:2]), .instr_o(instr)
    );

    decoder_2ri16 u_dec (
        .instr_i(instr), .decode_result_valid_o(dec_valid), .reg_read_valid_o(),
        .reg_read_addr_o(dec_raddr), .use_imm_o(), .imm_o(imm),
        .reg_write_valid_o(dec_we), .reg_write_addr_o(dec_waddr),
        .aluop_o(aluop), .alusel_o()
    );

    gpr_file u_gpr (
        .clk_i(clk_i), .reset_i(reset_i), .raddr_a_i(gpr_raddr_a),
        .raddr_b_i(dec_raddr[9:5]), .we_i(gpr_we), .waddr_i(gpr_waddr),
        .wdata_i(gpr_wdata), .rdata_a_o(rj_data), .rdata_b_o(rd_data)
    );

    branch_unit u_bru (
        .aluop_i(aluop), .pc_i(pc), .rj_data_i(rj_data), .rd_data_i(rd_data),
        .imm_i(imm), .next_pc_o(next_pc), .link_o(link)
    );

    step_counter u_steps (
        .clk_i(clk_i), .reset_i(reset_i), .load_i(start), .count_i(step_count),
        .retire_i(retire), .steps_zero_o(steps_zero), .retired_o(retired)
    );

    exec_fsm u_fsm (
        .clk_i(clk_i), .reset_i(reset_i), .start_i(start), .pc_wr_i(pc_wr),
        .pc_wdata_i(host_wdata), .steps_zero_i(steps_zero),
        .decode_valid_i(dec_valid), .reg_write_valid_i(dec_we),
        .reg_write_addr_i(dec_waddr), .next_pc_i(next_pc), .link_i(link),
        .fetch_en_o(fetch_en), .pc_o(pc), .gpr_we_o(fsm_gpr_we),
        .gpr_waddr_o(fsm_gpr_waddr), .gpr_wdata_o(fsm_gpr_wdata),
        .retire_o(retire), .state_o(state)
    );

endmodule

// File: branch_unit.sv
`timescale 1ns/10ps

module branch_unit (
    input  la_branch_pkg::alu_op_e aluop_i,
    input  logic [31:0]            pc_i,
    input  logic [31:0]            rj_data_i,
    input  logic [31:0]            rd_data_i,
    input  logic [31:0]            imm_i,
    output logic [31:0]            next_pc_o,
    output logic [31:0]            link_o
);
    import la_branch_pkg::*;

    logic        equal;
    logic        less_s;
    logic        less_u;
    logic        taken;
    logic [31:0] pc_plus4;

    assign equal    = (rj_data_i == rd_data_i);
    assign less_s   = ($signed(rj_data_i) < $signed(rd_data_i));
    assign less_u   = (rj_data_i < rd_data_i);
    assign pc_plus4 = pc_i + 32'd4;

    always_comb begin
        case (aluop_i)
            OP_BEQ:  taken = equal;
            OP_BNE:  taken = !equal;
            OP_BLT:  taken = less_s;
            OP_BGE:  taken = !less_s;
            OP_BLTU: taken = less_u;
            OP_BGEU: taken = !less_u;
            default: taken = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative
    always_comb begin
        if (aluop_i == OP_JIRL) begin
            next_pc_o = rj_data_i + imm_i;
        end else if (taken) begin
            next_pc_o = pc_i + imm_i;
        end else begin
            next_pc_o = pc_plus4;
        end
    end

    assign link_o = pc_plus4;

endmodule

// File: decoder_2ri16.sv
`timescale 1ns/10ps

// 2RI16 format {opcode[6], imm16[16], rj[5], rd[5]}, branch opcodes only
module decoder_2ri16 (
    input  logic [31:0]            instr_i,

    // high when the opcode is one of the seven branches
    output logic                   decode_result_valid_o,

    // bit 0 is rj, bit 1 is rd; address packed as {rd, rj}
    output logic [1:0]             reg_read_valid_o,
    output logic [9:0]             reg_read_addr_o,

    output logic                   use_imm_o,
    output logic [31:0]            imm_o,

    output logic                   reg_write_valid_o,
    output logic [4:0]             reg_write_addr_o,

    output la_branch_pkg::alu_op_e  aluop_o,
    output la_branch_pkg::alu_sel_e alusel_o
);
    import la_branch_pkg::*;

    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [15:0] imm16;

    assign rd    = instr_i[4:0];
    assign rj    = instr_i[9:5];
    assign imm16 = instr_i[25:10];

    always_comb begin
        // conditional branch defaults
        decode_result_valid_o = 1'b1;
        reg_read_valid_o      = 2'b11;
        reg_read_addr_o       = {rd, rj};
        use_imm_o             = 1'b1;
        imm_o                 = {{14{imm16[15]}}, imm16, 2'b00};
        reg_write_valid_o     = 1'b0;
        reg_write_addr_o      = 5'd0;
        aluop_o               = OP_NONE;
        alusel_o              = RES_JUMP;
        case (instr_i[31:26])
            OPC_JIRL: begin
                // reads rj only, link goes to rd
                aluop_o           = OP_JIRL;
                reg_read_valid_o  = 2'b01;
                reg_read_addr_o   = {5'd0, rj};
                reg_write_valid_o = 1'b1;
                reg_write_addr_o  = rd;
            end
            OPC_BEQ:  aluop_o = OP_BEQ;
            OPC_BNE:  aluop_o = OP_BNE;
            OPC_BLT:  aluop_o = OP_BLT;
            OPC_BGE:  aluop_o = OP_BGE;
            OPC_BLTU: aluop_o = OP_BLTU;
            OPC_BGEU: aluop_o = OP_BGEU;
            default: begin
                decode_result_valid_o = 1'b0;
                reg_read_valid_o      = 2'b00;
                reg_read_addr_o       = 10'd0;
                use_imm_o             = 1'b0;
                imm_o                 = 32'd0;
                alusel_o              = RES_NOP;
            end
        endcase
    end

endmodule

// File: exec_fsm.sv
`timescale 1ns/10ps

module exec_fsm (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       start_i,
    input  logic                       pc_wr_i,
    input  logic [31:0]                pc_wdata_i,
    input  logic                       steps_zero_i,
    input  logic                       decode_valid_i,
    input  logic                       reg_write_valid_i,
    input  logic [4:0]                 reg_write_addr_i,
    input  logic [31:0]                next_pc_i,
    input  logic [31:0]                link_i,
    output logic                       fetch_en_o,
    output logic [31:0]                pc_o,
    output logic                       gpr_we_o,
    output logic [4:0]                 gpr_waddr_o,
    output logic [31:0]                gpr_wdata_o,
    output logic                       retire_o,
    output la_branch_pkg::exec_state_e state_o
);
    import la_branch_pkg::*;

    exec_state_e state_q;
    exec_state_e state_d;
    logic [31:0] next_pc_q;
    logic        wb_we_q;
    logic        stopped;

    assign stopped = (state_q == S_IDLE) || (state_q == S_DONE) || (state_q == S_FAULT);

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE, S_DONE, S_FAULT: begin
                if (start_i) begin
                    state_d = S_FETCH;
                end
            end
            // step count is checked before every fetch
            S_FETCH: state_d = steps_zero_i ? S_DONE : S_EXEC;
            S_EXEC:  state_d = decode_valid_i ? S_WB : S_FAULT;
            S_WB:    state_d = S_FETCH;
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= S_IDLE;
            pc_o    <= 32'd0;
        end else begin
            state_q <= state_d;
            if (state_q == S_WB) begin
                pc_o <= next_pc_q;
            end else if (pc_wr_i && stopped) begin
                pc_o <= pc_wdata_i;
            end
        end
    end

    // writeback payload captured in exec
    always_ff @(posedge clk_i) begin
        if (state_q == S_EXEC) begin
            next_pc_q   <= next_pc_i;
            wb_we_q     <= reg_write_valid_i;
            gpr_waddr_o <= reg_write_addr_i;
            gpr_wdata_o <= link_i;
        end
    end

    assign fetch_en_o = (state_q == S_FETCH) && !steps_zero_i;
    assign gpr_we_o   = (state_q == S_WB) && wb_we_q;
    assign retire_o   = (state_q == S_WB);
    assign state_o    = state_q;

endmodule

// File: gpr_file.sv
`timescale 1ns/10ps

module gpr_file (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic [4:0]  raddr_a_i,
    input  logic [4:0]  raddr_b_i,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_a_o,
    output logic [31:0] rdata_b_o
);

    logic [31:0] regs [32];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            // r0 never takes a write
            regs[waddr_i] <= wdata_i;
        end
    end

    // asynchronous reads, r0 hardwired to zero
    assign rdata_a_o = (raddr_a_i == 5'd0) ? 32'd0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == 5'd0) ? 32'd0 : regs[raddr_b_i];

endmodule

// File: inst_mem.sv
`timescale 1ns/10ps

module inst_mem #(
    parameter int IMEM_DEPTH = 16
) (
    input  logic                          clk_i,
    input  logic                          host_we_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0] host_addr_i,
    input  logic [31:0]                   host_wdata_i,
    input  logic                          fetch_en_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0] fetch_addr_i,
    output logic [31:0]                   instr_o
);

    logic [31:0] mem [IMEM_DEPTH];

    always_ff @(posedge clk_i) begin
        if (host_we_i) begin
            mem[host_addr_i] <= host_wdata_i;
        end
        // fetch word held until the next fetch
        if (fetch_en_i) begin
            instr_o <= mem[fetch_addr_i];
        end
    end

endmodule

// File: la_branch_pkg.sv
package la_branch_pkg;

    // 2RI16 major opcodes, instr[31:26]
    typedef enum logic [5:0] {
        OPC_JIRL = 6'h13,
        OPC_BEQ  = 6'h16,
        OPC_BNE  = 6'h17,
        OPC_BLT  = 6'h18,
        OPC_BGE  = 6'h19,
        OPC_BLTU = 6'h1a,
        OPC_BGEU = 6'h1b
    } opcode_e;

    // branch operation handed from decoder to branch unit
    typedef enum logic [7:0] {
        OP_NONE = 8'h00,
        OP_JIRL = 8'h01,
        OP_BEQ  = 8'h02,
        OP_BNE  = 8'h03,
        OP_BLT  = 8'h04,
        OP_BGE  = 8'h05,
        OP_BLTU = 8'h06,
        OP_BGEU = 8'h07
    } alu_op_e;

    // result select
    typedef enum logic [2:0] {
        RES_NOP  = 3'b000,
        RES_JUMP = 3'b001
    } alu_sel_e;

    // sequencer states, the status bits are derived from this encoding
    typedef enum logic [2:0] {
        S_IDLE  = 3'd0,
        S_FETCH = 3'd1,
        S_EXEC  = 3'd2,
        S_WB    = 3'd3,
        S_DONE  = 3'd4,
        S_FAULT = 3'd5
    } exec_state_e;

    // APB register map
    localparam logic [11:0] ADDR_CTRL      = 12'h000;
    localparam logic [11:0] ADDR_STATUS    = 12'h004;
    localparam logic [11:0] ADDR_PC        = 12'h008;
    localparam logic [11:0] ADDR_RETIRED   = 12'h00C;
    localparam logic [11:0] ADDR_GPR_BASE  = 12'h100;
    localparam logic [11:0] ADDR_IMEM_BASE = 12'h200;

endpackage

// File: project.f
la_branch_pkg.sv
decoder_2ri16.sv
gpr_file.sv
branch_unit.sv
inst_mem.sv
step_counter.sv
exec_fsm.sv
apb_csr.sv
branch_core_top.sv
tb_branch_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_branch_core -f project.f -o tb_sim

# the simulation exits non-zero on failure, so capture before deciding
out=$(./obj_dir/tb_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi

// File: step_counter.sv
`timescale 1ns/10ps

module step_counter (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       load_i,
    input  logic [7:0] count_i,
    input  logic       retire_i,
    output logic       steps_zero_o,
    output logic [7:0] retired_o
);

    logic [7:0] remaining_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            remaining_q <= 8'd0;
            retired_o   <= 8'd0;
        end else if (load_i) begin
            remaining_q <= count_i;
            retired_o   <= 8'd0;
        end else if (retire_i) begin
            // sequencer never retires past zero
            remaining_q <= remaining_q - 8'd1;
            retired_o   <= retired_o + 8'd1;
        end
    end

    assign steps_zero_o = (remaining_q == 8'd0);

endmodule

// File: tb_branch_core.sv
`timescale 1ns/10ps

module tb_branch_core;
    import la_branch_pkg::*;

    localparam int IMEM_DEPTH = 16;
    localparam int CLK_PERIOD = 40;

    // cycle budget per test group, three cycles per APB transfer
    localparam int RESET_CYCLES    = 16;
    localparam int INIT_CYCLES     = 150;
    localparam int COND_CYCLES     = 24 * 160;
    localparam int JIRL_CYCLES     = 3 * 160;
    localparam int PROGRAM_CYCLES  = 3 * 500;
    localparam int FAULT_CYCLES    = 400;
    localparam int BUSY_CYCLES     = 1600;
    localparam int WATCHDOG_MARGIN = 3;
    localparam int WATCHDOG_NS     = (RESET_CYCLES + INIT_CYCLES + COND_CYCLES + JIRL_CYCLES +
                                      PROGRAM_CYCLES + FAULT_CYCLES + BUSY_CYCLES) *
                                     WATCHDOG_MARGIN * CLK_PERIOD;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] lfsr_state = 32'h5ff21d24;
    int          errors;

    // reference model state
    logic [31:0] ref_gpr [32];
    logic [31:0] ref_imem [IMEM_DEPTH];
    logic [31:0] ref_pc;
    logic [7:0]  ref_retired;
    logic        ref_fault;

    branch_core_top #(
        .IMEM_DEPTH(IMEM_DEPTH)
    ) UUT (
        .clk_i(clk), .reset_i(reset), .psel_i(psel), .penable_i(penable),
        .pwrite_i(pwrite), .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata),
        .pready_o(pready), .pslverr_o(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the simulation ran longer than all tests together");
        $display("tests failed");
        $fatal(1, "watchdog timeout");
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = 32'd0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] encode(input logic [5:0] opc, input logic [15:0] imm16,
                                           input logic [4:0] rj, input logic [4:0] rd);
        return {opc, imm16, rj, rd};
    endfunction

    function automatic logic [5:0] opcode_for(input logic [2:0] k);
        case (k)
            3'd0:    return OPC_JIRL;
            3'd1:    return OPC_BEQ;
            3'd2:    return OPC_BNE;
            3'd3:    return OPC_BLT;
            3'd4:    return OPC_BGE;
            3'd5:    return OPC_BLTU;
            3'd6:    return OPC_BGEU;
            default: return OPC_BEQ;
        endcase
    endfunction

    function automatic logic [11:0] gpr_addr(input logic [4:0] idx);
        return ADDR_GPR_BASE + {5'd0, idx, 2'b00};
    endfunction

    function automatic logic [11:0] imem_addr(input logic [3:0] slot);
        return ADDR_IMEM_BASE + {6'd0, slot, 2'b00};
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        assert (actual === expected) else begin
            errors++;
            $display("[ERROR] %0t: %s is 0x%08h, expected 0x%08h", $time, what, actual,
                     expected);
            $display("tests failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic do_transfer(input logic wr, input logic [11:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        // access cycle, sampled well before the rising edge
        #(CLK_PERIOD / 4);
        rdata = prdata;
        err   = pslverr;
        check_equal({31'd0, pready}, 32'd1, "pready");
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        do_transfer(1'b1, addr, data, rdata, err);
        check_equal({31'd0, err}, {31'd0, exp_err}, $sformatf("pslverr of write 0x%03h", addr));
    endtask

    task automatic apb_read(input logic [11:0] addr, input logic exp_err,
                            output logic [31:0] data);
        logic err;
        do_transfer(1'b0, addr, 32'd0, data, err);
        check_equal({31'd0, err}, {31'd0, exp_err}, $sformatf("pslverr of read 0x%03h", addr));
    endtask

    task automatic set_gpr(input logic [4:0] idx, input logic [31:0] val);
        apb_write(gpr_addr(idx), val, 1'b0);
        if (idx != 5'd0) begin
            ref_gpr[idx] = val;
        end
    endtask

    task automatic load_imem(input logic [3:0] slot, input logic [31:0] word);
        apb_write(imem_addr(slot), word, 1'b0);
        ref_imem[slot] = word;
    endtask

    task automatic set_pc(input logic [31:0] val);
        apb_write(ADDR_PC, val, 1'b0);
        ref_pc = val;
    endtask

    task automatic load_random_gprs();
        logic [31:0] r;
        for (int i = 1; i < 32; i++) begin
            r = rand_bits(32);
            set_gpr(5'(i), r);
        end
    endtask

    // executes the branch rules over the model copies
    task automatic model_run(input int steps);
        logic [31:0] word;
        logic [31:0] rj_val;
        logic [31:0] rd_val;
        logic [31:0] imm;
        logic [31:0] next_pc;
        logic        taken;
        logic        stop;
        ref_retired = 8'd0;
        ref_fault   = 1'b0;
        stop        = 1'b0;
        for (int i = 0; i < steps && !stop; i++) begin
            word    = ref_imem[ref_pc[5:2]];
            rj_val  = ref_gpr[word[9:5]];
            rd_val  = ref_gpr[word[4:0]];
            imm     = {{14{word[25]}}, word[25:10], 2'b00};
            taken   = 1'b0;
            next_pc = ref_pc + 32'd4;
            case (word[31:26])
                OPC_JIRL: next_pc = rj_val + imm;
                OPC_BEQ:  taken = (rj_val == rd_val);
                OPC_BNE:  taken = (rj_val != rd_val);
                OPC_BLT:  taken = ($signed(rj_val) < $signed(rd_val));
                OPC_BGE:  taken = ($signed(rj_val) >= $signed(rd_val));
                OPC_BLTU: taken = (rj_val < rd_val);
                OPC_BGEU: taken = (rj_val >= rd_val);
                default: begin
                    ref_fault = 1'b1;
                    stop      = 1'b1;
                end
            endcase
            if (!stop) begin
                if (word[31:26] == OPC_JIRL && word[4:0] != 5'd0) begin
                    ref_gpr[word[4:0]] = ref_pc + 32'd4;
                end
                if (taken) begin
                    next_pc = ref_pc + imm;
                end
                ref_pc      = next_pc;
                ref_retired = ref_retired + 8'd1;
            end
        end
    endtask

    task automatic wait_run_end(input int steps);
        logic [31:0] status;
        int          polls;
        polls  = 0;
        status = 32'd1;
        while (status[0] && polls <= 2 * steps + 20) begin
            apb_read(ADDR_STATUS, 1'b0, status);
            polls++;
        end
        if (status[0]) begin
            $display("timeout: the core is still busy after %0d status polls", polls);
            $display("tests failed");
            $fatal(1, "run did not finish");
        end
    endtask

    task automatic check_state();
        logic [31:0] data;
        apb_read(ADDR_PC, 1'b0, data);
        check_equal(data, ref_pc, "PC");
        apb_read(ADDR_RETIRED, 1'b0, data);
        check_equal(data, {24'd0, ref_retired}, "RETIRED");
        apb_read(ADDR_STATUS, 1'b0, data);
        check_equal(data, {29'd0, ref_fault, !ref_fault, 1'b0}, "STATUS");
        for (int i = 0; i < 32; i++) begin
            apb_read(gpr_addr(5'(i)), 1'b0, data);
            check_equal(data, ref_gpr[i], $sformatf("r%0d", i));
        end
    endtask

    task automatic run_program(input logic [7:0] count);
        apb_write(ADDR_CTRL, {24'd0, count}, 1'b0);
        wait_run_end(int'(count));
        model_run(int'(count));
        check_state();
    endtask

    // one instruction at a random aligned pc
    task automatic run_single(input logic [5:0] opc, input logic [4:0] rj, input logic [4:0] rd,
                              input logic [31:0] rj_val, input logic [31:0] rd_val,
                              input logic [15:0] imm16);
        logic [31:0] r;
        r = rand_bits(32);
        set_gpr(rj, rj_val);
        set_gpr(rd, rd_val);
        set_pc({r[31:2], 2'b00});
        load_imem(r[5:2], encode(opc, imm16, rj, rd));
        run_program(8'd1);
    endtask

    task automatic check_after_reset();
        logic [31:0] data;
        ref_pc     = 32'd0;
        ref_gpr[0] = 32'd0;
        apb_read(ADDR_STATUS, 1'b0, data);
        check_equal(data, 32'd0, "STATUS after reset");
        apb_read(ADDR_PC, 1'b0, data);
        check_equal(data, 32'd0, "PC after reset");
        apb_read(ADDR_RETIRED, 1'b0, data);
        check_equal(data, 32'd0, "RETIRED after reset");
        set_gpr(5'd0, 32'hdeadbeef);
        apb_read(gpr_addr(5'd0), 1'b0, data);
        check_equal(data, 32'd0, "r0 after write");
        load_random_gprs();
    endtask

    task automatic run_cond_branches();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [4:0]  rj;
        logic [4:0]  rd;
        for (int k = 1; k <= 6; k++) begin
            for (int kind = 0; kind < 4; kind++) begin
                a  = rand_bits(32);
                b  = rand_bits(32);
                r  = rand_bits(21);
                rj = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
                rd = (rj == 5'd31) ? 5'd1 : rj + 5'd1;
                // equal values, then both sign mixes, then plain random
                case (kind)
                    0: b = a;
                    1: begin
                        a[31] = 1'b1;
                        b[31] = 1'b0;
                    end
                    2: begin
                        a[31] = 1'b0;
                        b[31] = 1'b1;
                    end
                    default: ;
                endcase
                run_single(opcode_for(3'(k)), rj, rd, a, b, r[20:5]);
            end
        end
    endtask

    task automatic run_jirl_cases();
        logic [31:0] r;
        logic [31:0] v;
        r = rand_bits(26);
        v = rand_bits(32);
        run_single(OPC_JIRL, 5'd7, 5'd12, v, 32'd0, {1'b0, r[14:0]});
        // negative offset
        v = rand_bits(32);
        run_single(OPC_JIRL, 5'd3, 5'd30, v, 32'd0, {1'b1, r[25:11]});
        // link into r0 is dropped
        v = rand_bits(32);
        run_single(OPC_JIRL, 5'd9, 5'd0, v, 32'd0, r[15:0]);
    endtask

    task automatic run_random_programs();
        logic [31:0] r;
        logic [31:0] imm;
        logic [31:0] regs;
        for (int p = 0; p < 3; p++) begin
            load_random_gprs();
            r = rand_bits(32);
            set_pc({r[31:2], 2'b00});
            for (int s = 0; s < IMEM_DEPTH; s++) begin
                r    = rand_bits(3);
                imm  = rand_bits(16);
                regs = rand_bits(10);
                load_imem(4'(s), encode(opcode_for(r[2:0]), imm[15:0], regs[9:5], regs[4:0]));
            end
            r = rand_bits(5);
            run_program(8'd1 + {3'd0, r[4:0]});
        end
    endtask

    task automatic check_fault_and_zero();
        logic [31:0] r;
        r = rand_bits(32);
        set_pc({r[31:2], 2'b00});
        load_imem(r[5:2], encode(6'h15, r[31:16], 5'd4, 5'd5));
        run_program(8'd3);
        // zero steps straight to done
        run_program(8'd0);
    endtask

    task automatic check_busy_writes();
        logic [31:0] data;
        set_pc(32'd0);
        // beq r0, r0, 0 spins on slot 0
        load_imem(4'd0, encode(OPC_BEQ, 16'd0, 5'd0, 5'd0));
        apb_write(ADDR_CTRL, 32'd200, 1'b0);
        apb_write(gpr_addr(5'd5), 32'h12345678, 1'b1);
        apb_write(imem_addr(4'd0), 32'hffffffff, 1'b1);
        apb_write(ADDR_PC, 32'h40, 1'b1);
        apb_write(ADDR_CTRL, 32'd5, 1'b1);
        apb_read(ADDR_STATUS, 1'b0, data);
        check_equal(data & 32'd1, 32'd1, "busy bit during run");
        wait_run_end(200);
        model_run(200);
        check_state();
        // slot 0 must still hold the branch
        run_program(8'd1);
        // imem is write only
        apb_read(imem_addr(4'd0), 1'b0, data);
        check_equal(data, 32'd0, "IMEM read");
        apb_write(12'h010, 32'd1, 1'b1);
        apb_write(12'h240, 32'd1, 1'b1);
        apb_write(ADDR_STATUS, 32'd0, 1'b1);
        apb_write(ADDR_RETIRED, 32'd0, 1'b1);
        apb_read(12'h180, 1'b1, data);
    endtask

    initial begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 12'd0;
        pwdata  = 32'd0;
        reset   = 1'b1;
        errors  = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        check_after_reset();
        run_cond_branches();
        run_jirl_cases();
        run_random_programs();
        check_fault_and_zero();
        check_busy_writes();
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
